//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       := tb_vio_switch
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "All tests passed!" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/vio_egress_arbiter.sv
`timescale 1ns/1ns

module vio_egress_arbiter (
  input  logic                                                           aclk,
  input  logic                                                           rst,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                             my_port_hits,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                             in_tvalid,
  input  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::DATA_BITS-1:0] in_tdata,
  input  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::KEEP_BITS-1:0] in_tkeep,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                             in_tlast,
  input  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::PID_BITS-1:0]  in_tid,
  input  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::DEST_BITS-1:0] in_tdest,
  input  logic                                                           slice_ready,
  output logic [vio_switch_pkg::N_PORTS-1:0]                             take,
  output logic                                                           out_tvalid,
  output logic [vio_switch_pkg::DATA_BITS-1:0]                           out_tdata,
  output logic [vio_switch_pkg::KEEP_BITS-1:0]                           out_tkeep,
  output logic                                                           out_tlast,
  output logic [vio_switch_pkg::PID_BITS-1:0]                            out_tid,
  output logic [vio_switch_pkg::DEST_BITS-1:0]                           out_tdest
);

  logic                                 lock_q;
  logic [vio_switch_pkg::PORT_BITS-1:0] lock_idx_q;
  logic [vio_switch_pkg::PORT_BITS-1:0] rr_q;

  logic                                 grant_any;
  logic [vio_switch_pkg::PORT_BITS-1:0] grant_idx;
  logic [vio_switch_pkg::PORT_BITS-1:0] sel;
  logic                                 take_beat;

  // Round-robin scan starting at the pointer, first requester wins
  always_comb begin : grant_scan
    logic [vio_switch_pkg::PORT_BITS-1:0] cand;
    grant_any = 1'b0;
    grant_idx = rr_q;
    for (int k = 0; k < vio_switch_pkg::N_PORTS; k++) begin
      cand = vio_switch_pkg::PORT_BITS'((int'(rr_q) + k) % vio_switch_pkg::N_PORTS);
      if (!grant_any && my_port_hits[cand]) begin
        grant_any = 1'b1;
        grant_idx = cand;
      end
    end
  end

  // A locked packet keeps the output, otherwise the fresh grant drives it
  assign sel        = lock_q ? lock_idx_q : grant_idx;
  assign out_tvalid = lock_q ? in_tvalid[lock_idx_q] : grant_any;

  assign out_tdata = in_tdata[sel];
  assign out_tkeep = in_tkeep[sel];
  assign out_tlast = in_tlast[sel];
  assign out_tid   = in_tid[sel];
  assign out_tdest = in_tdest[sel];

  assign take_beat = out_tvalid && slice_ready;

  always_comb begin
    take = '0;
    take[sel] = take_beat;
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      rr_q       <= '0;
    end else begin
      // Hold a fresh grant so the offered beat stays stable while the slice is full
      if (!lock_q && grant_any) begin
        lock_q     <= 1'b1;
        lock_idx_q <= grant_idx;
      end
      // Release on the tlast beat and hand priority to the next input
      if (take_beat && in_tlast[sel]) begin
        lock_q <= 1'b0;
        rr_q   <= vio_switch_pkg::PORT_BITS'((int'(sel) + 1) % vio_switch_pkg::N_PORTS);
      end
    end
  end

endmodule

//--- hw/vio_egress_slice.sv
`timescale 1ns/1ns

module vio_egress_slice (
  input  logic                                 aclk,
  input  logic                                 rst,
  input  logic                                 in_tvalid,
  input  logic [vio_switch_pkg::DATA_BITS-1:0] in_tdata,
  input  logic [vio_switch_pkg::KEEP_BITS-1:0] in_tkeep,
  input  logic                                 in_tlast,
  input  logic [vio_switch_pkg::PID_BITS-1:0]  in_tid,
  input  logic [vio_switch_pkg::DEST_BITS-1:0] in_tdest,
  output logic                                 in_tready,
  output logic                                 src_tvalid,
  output logic [vio_switch_pkg::DATA_BITS-1:0] src_tdata,
  output logic [vio_switch_pkg::KEEP_BITS-1:0] src_tkeep,
  output logic                                 src_tlast,
  output logic [vio_switch_pkg::PID_BITS-1:0]  src_tid,
  output logic [vio_switch_pkg::DEST_BITS-1:0] src_tdest,
  input  logic                                 src_tready
);

  // Skid entry catches the beat that arrives while the output stalls
  logic                                 skid_valid;
  logic [vio_switch_pkg::DATA_BITS-1:0] skid_tdata;
  logic [vio_switch_pkg::KEEP_BITS-1:0] skid_tkeep;
  logic                                 skid_tlast;
  logic [vio_switch_pkg::PID_BITS-1:0]  skid_tid;
  logic [vio_switch_pkg::DEST_BITS-1:0] skid_tdest;

  logic main_free;

  // Ready comes straight from a flop, so the output ready path is cut
  assign in_tready = !skid_valid;
  assign main_free = !src_tvalid || src_tready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      src_tvalid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      src_tvalid <= skid_valid || in_tvalid;
      skid_valid <= 1'b0;
    end else if (in_tvalid && in_tready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free) begin
      // Skid content is older and goes out first
      src_tdata <= skid_valid ? skid_tdata : in_tdata;
      src_tkeep <= skid_valid ? skid_tkeep : in_tkeep;
      src_tlast <= skid_valid ? skid_tlast : in_tlast;
      src_tid   <= skid_valid ? skid_tid : in_tid;
      src_tdest <= skid_valid ? skid_tdest : in_tdest;
    end
    if (!main_free && in_tready) begin
      skid_tdata <= in_tdata;
      skid_tkeep <= in_tkeep;
      skid_tlast <= in_tlast;
      skid_tid   <= in_tid;
      skid_tdest <= in_tdest;
    end
  end

endmodule

//--- hw/vio_ingress_decode.sv
`timescale 1ns/1ns

module vio_ingress_decode (
  input  logic                                 aclk,
  input  logic                                 rst,
  input  logic                                 sink_tvalid,
  input  logic                                 sink_tlast,
  input  logic [vio_switch_pkg::DEST_BITS-1:0] sink_tdest,
  input  logic                                 accept,
  output logic                                 req_valid,
  output logic [vio_switch_pkg::PORT_BITS-1:0] req_port,
  output logic                                 sink_tready,
  output logic                                 decode_err
);

  // Packet state, meaningful between the head beat and the tlast beat
  logic                                 in_pkt_q;
  logic                                 drop_q;
  logic [vio_switch_pkg::PORT_BITS-1:0] port_q;

  logic                                 head_ok;
  logic                                 cur_drop;
  logic [vio_switch_pkg::PORT_BITS-1:0] cur_port;
  logic                                 beat_acc;

  // Only tdest values below the port count name an existing output
  assign head_ok = sink_tdest < vio_switch_pkg::DEST_BITS'(vio_switch_pkg::N_PORTS);

  // Head beat decodes the live tdest, later beats reuse the locked result
  assign cur_drop = in_pkt_q ? drop_q : !head_ok;
  assign cur_port = in_pkt_q ? port_q : sink_tdest[vio_switch_pkg::PORT_BITS-1:0];

  assign req_valid = sink_tvalid && !cur_drop;
  assign req_port  = cur_port;

  // Bad packets are swallowed at full rate, good ones wait for an arbiter
  assign sink_tready = cur_drop || accept;
  assign beat_acc    = sink_tvalid && sink_tready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      in_pkt_q   <= 1'b0;
      drop_q     <= 1'b0;
      decode_err <= 1'b0;
    end else begin
      // One pulse per bad packet, raised by its head beat
      decode_err <= beat_acc && !in_pkt_q && !head_ok;
      if (beat_acc) begin
        in_pkt_q <= !sink_tlast;
        drop_q   <= cur_drop;
      end
    end
  end

  // Destination of the packet in flight
  always_ff @(posedge aclk) begin
    if (beat_acc && !in_pkt_q) begin
      port_q <= cur_port;
    end
  end

endmodule

//--- hw/vio_switch.sv
`timescale 1ns/1ns

module vio_switch (
  input  logic                                                              aclk,
  input  logic                                                              rst,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                                sink_tvalid,
  output logic [vio_switch_pkg::N_PORTS-1:0]                                sink_tready,
  input  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::DATA_BITS-1:0] sink_tdata,
  input  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::KEEP_BITS-1:0] sink_tkeep,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                                sink_tlast,
  input  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::PID_BITS-1:0]  sink_tid,
  input  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::DEST_BITS-1:0] sink_tdest,
  output logic [vio_switch_pkg::N_PORTS-1:0]                                src_tvalid,
  input  logic [vio_switch_pkg::N_PORTS-1:0]                                src_tready,
  output logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::DATA_BITS-1:0] src_tdata,
  output logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::KEEP_BITS-1:0] src_tkeep,
  output logic [vio_switch_pkg::N_PORTS-1:0]                                src_tlast,
  output logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::PID_BITS-1:0]  src_tid,
  output logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::DEST_BITS-1:0] src_tdest,
  output logic [vio_switch_pkg::N_PORTS-1:0]                                s_decode_err
);

  // Ingress requests
  logic [vio_switch_pkg::N_PORTS-1:0]                                req_valid;
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::PORT_BITS-1:0] req_port;
  logic [vio_switch_pkg::N_PORTS-1:0]                                accept;

  // Crossbar matrices, outer index output, inner index input
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::N_PORTS-1:0] port_hits;
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::N_PORTS-1:0] take;
  // Transposed take, outer index input
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::N_PORTS-1:0] take_by_in;

  // Arbiter to slice beats
  logic [vio_switch_pkg::N_PORTS-1:0]                                arb_tvalid;
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::DATA_BITS-1:0] arb_tdata;
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::KEEP_BITS-1:0] arb_tkeep;
  logic [vio_switch_pkg::N_PORTS-1:0]                                arb_tlast;
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::PID_BITS-1:0]  arb_tid;
  logic [vio_switch_pkg::N_PORTS-1:0][vio_switch_pkg::DEST_BITS-1:0] arb_tdest;
  logic [vio_switch_pkg::N_PORTS-1:0]                                slice_ready;

  for (genvar i = 0; i < vio_switch_pkg::N_PORTS; i++) begin : g_in
    vio_ingress_decode u_decode (
      .aclk        (aclk),
      .rst         (rst),
      .sink_tvalid (sink_tvalid[i]),
      .sink_tlast  (sink_tlast[i]),
      .sink_tdest  (sink_tdest[i]),
      .accept      (accept[i]),
      .req_valid   (req_valid[i]),
      .req_port    (req_port[i]),
      .sink_tready (sink_tready[i]),
      .decode_err  (s_decode_err[i])
    );

    // An input is accepted by whichever output currently takes its beat
    for (genvar o = 0; o < vio_switch_pkg::N_PORTS; o++) begin : g_col
      assign take_by_in[i][o] = take[o][i];
    end
    assign accept[i] = |take_by_in[i];
  end

  for (genvar o = 0; o < vio_switch_pkg::N_PORTS; o++) begin : g_out
    for (genvar i = 0; i < vio_switch_pkg::N_PORTS; i++) begin : g_hit
      assign port_hits[o][i] =
        req_valid[i] && (req_port[i] == vio_switch_pkg::PORT_BITS'(o));
    end

    vio_egress_arbiter u_arbiter (
      .aclk         (aclk),
      .rst          (rst),
      .my_port_hits (port_hits[o]),
      .in_tvalid    (sink_tvalid),
      .in_tdata     (sink_tdata),
      .in_tkeep     (sink_tkeep),
      .in_tlast     (sink_tlast),
      .in_tid       (sink_tid),
      .in_tdest     (sink_tdest),
      .slice_ready  (slice_ready[o]),
      .take         (take[o]),
      .out_tvalid   (arb_tvalid[o]),
      .out_tdata    (arb_tdata[o]),
      .out_tkeep    (arb_tkeep[o]),
      .out_tlast    (arb_tlast[o]),
      .out_tid      (arb_tid[o]),
      .out_tdest    (arb_tdest[o])
    );

    vio_egress_slice u_slice (
      .aclk       (aclk),
      .rst        (rst),
      .in_tvalid  (arb_tvalid[o]),
      .in_tdata   (arb_tdata[o]),
      .in_tkeep   (arb_tkeep[o]),
      .in_tlast   (arb_tlast[o]),
      .in_tid     (arb_tid[o]),
      .in_tdest   (arb_tdest[o]),
      .in_tready  (slice_ready[o]),
      .src_tvalid (src_tvalid[o]),
      .src_tdata  (src_tdata[o]),
      .src_tkeep  (src_tkeep[o]),
      .src_tlast  (src_tlast[o]),
      .src_tid    (src_tid[o]),
      .src_tdest  (src_tdest[o]),
      .src_tready (src_tready[o])
    );
  end

endmodule

//--- hw/vio_switch_pkg.sv
package vio_switch_pkg;

  // Number of sink ports and source ports on the crossbar
  localparam int N_PORTS = 4;

  // Stream payload widths
  localparam int DATA_BITS = 64;
  localparam int KEEP_BITS = DATA_BITS / 8;

  // Packet id carried on tid
  localparam int PID_BITS = 6;

  // Full tdest width as seen on the stream
  localparam int DEST_BITS = 14;

  // Width of a port index, the low tdest bits of a routable packet
  localparam int PORT_BITS = $clog2(N_PORTS);

endpackage

//--- tb/vio_switch_vectors.svh
`ifndef VIO_SWITCH_VECTORS_SVH
`define VIO_SWITCH_VECTORS_SVH

// Columns: input port, tdest, tid, beats, last beat tkeep, phase
typedef struct packed {
  logic [vio_switch_pkg::PORT_BITS-1:0] src;
  logic [vio_switch_pkg::DEST_BITS-1:0] dest;
  logic [vio_switch_pkg::PID_BITS-1:0]  tid;
  logic [3:0]                           len;
  logic [vio_switch_pkg::KEEP_BITS-1:0] last_keep;
  logic [2:0]                           phase;
} pkt_row_t;

localparam int HALF     = vio_switch_pkg::DATA_BITS / 2;
localparam int N_ROWS   = 31;
localparam int N_PHASES = 6;

localparam pkt_row_t ROWS [N_ROWS] = '{
  // One packet per output
  '{2'd0, 14'd1, 6'd1, 4'd3, 8'h0f, 3'd0},
  '{2'd1, 14'd2, 6'd2, 4'd1, 8'hff, 3'd0},
  '{2'd2, 14'd3, 6'd3, 4'd4, 8'h01, 3'd0},
  '{2'd3, 14'd0, 6'd4, 4'd2, 8'h3f, 3'd0},
  // Inputs 1 and 2 fight for output 3
  '{2'd1, 14'd3, 6'd5, 4'd4, 8'hff, 3'd1},
  '{2'd1, 14'd3, 6'd6, 4'd2, 8'h07, 3'd1},
  '{2'd2, 14'd3, 6'd7, 4'd3, 8'hff, 3'd1},
  '{2'd2, 14'd3, 6'd8, 4'd1, 8'h1f, 3'd1},
  '{2'd0, 14'd0, 6'd9, 4'd5, 8'hff, 3'd1},
  '{2'd3, 14'd1, 6'd10, 4'd2, 8'h03, 3'd1},
  // Three-way contention on output 2
  '{2'd0, 14'd2, 6'd11, 4'd2, 8'hff, 3'd2},
  '{2'd0, 14'd2, 6'd12, 4'd3, 8'h7f, 3'd2},
  '{2'd3, 14'd2, 6'd13, 4'd2, 8'hff, 3'd2},
  '{2'd3, 14'd2, 6'd14, 4'd1, 8'h01, 3'd2},
  '{2'd1, 14'd2, 6'd15, 4'd3, 8'h0f, 3'd2},
  // Back to back packets on one input/output pair
  '{2'd2, 14'd1, 6'd16, 4'd1, 8'hff, 3'd3},
  '{2'd2, 14'd1, 6'd17, 4'd2, 8'h03, 3'd3},
  '{2'd2, 14'd1, 6'd18, 4'd1, 8'h0f, 3'd3},
  '{2'd2, 14'd1, 6'd19, 4'd3, 8'hff, 3'd3},
  '{2'd0, 14'd0, 6'd20, 4'd2, 8'h3f, 3'd3},
  '{2'd0, 14'd0, 6'd21, 4'd1, 8'hff, 3'd3},
  // Undecodable tdest, then a good packet from the same input
  '{2'd1, 14'd4, 6'd22, 4'd3, 8'hff, 3'd4},
  '{2'd1, 14'h3fff, 6'd23, 4'd1, 8'h01, 3'd4},
  '{2'd1, 14'd0, 6'd24, 4'd2, 8'h0f, 3'd4},
  '{2'd3, 14'd9, 6'd25, 4'd2, 8'hff, 3'd4},
  '{2'd3, 14'd3, 6'd26, 4'd1, 8'h07, 3'd4},
  '{2'd0, 14'd2, 6'd27, 4'd2, 8'hff, 3'd4},
  // Mixed traffic
  '{2'd0, 14'd3, 6'd28, 4'd4, 8'hff, 3'd5},
  '{2'd1, 14'd0, 6'd29, 4'd3, 8'h1f, 3'd5},
  '{2'd2, 14'd0, 6'd30, 4'd2, 8'hff, 3'd5},
  '{2'd3, 14'd1, 6'd31, 4'd5, 8'h0f, 3'd5}
};

// Row index in the high half, beat number in the low half
function automatic logic [vio_switch_pkg::DATA_BITS-1:0] beat_data(input int r, input int b);
  return {HALF'(r), HALF'(b)};
endfunction

// All bytes valid except on the last beat
function automatic logic [vio_switch_pkg::KEEP_BITS-1:0] beat_keep(input int r, input int b);
  return (b == int'(ROWS[r].len) - 1) ? ROWS[r].last_keep : '1;
endfunction

function automatic logic is_bad_dest(input int r);
  return int'(ROWS[r].dest) >= vio_switch_pkg::N_PORTS;
endfunction

function automatic int total_beats();
  int sum;
  sum = 0;
  for (int r = 0; r < N_ROWS; r++) begin
    sum += int'(ROWS[r].len);
  end
  return sum;
endfunction

`endif

//--- tb/tb_vio_switch.sv
`timescale 1ns/1ns

module tb_vio_switch;

  localparam int NP = vio_switch_pkg::N_PORTS;

  logic                                          aclk;
  logic                                          rst;
  logic [NP-1:0]                                 sink_tvalid;
  logic [NP-1:0]                                 sink_tready;
  logic [NP-1:0][vio_switch_pkg::DATA_BITS-1:0]  sink_tdata;
  logic [NP-1:0][vio_switch_pkg::KEEP_BITS-1:0]  sink_tkeep;
  logic [NP-1:0]                                 sink_tlast;
  logic [NP-1:0][vio_switch_pkg::PID_BITS-1:0]   sink_tid;
  logic [NP-1:0][vio_switch_pkg::DEST_BITS-1:0]  sink_tdest;
  logic [NP-1:0]                                 src_tvalid;
  logic [NP-1:0]                                 src_tready;
  logic [NP-1:0][vio_switch_pkg::DATA_BITS-1:0]  src_tdata;
  logic [NP-1:0][vio_switch_pkg::KEEP_BITS-1:0]  src_tkeep;
  logic [NP-1:0]                                 src_tlast;
  logic [NP-1:0][vio_switch_pkg::PID_BITS-1:0]   src_tid;
  logic [NP-1:0][vio_switch_pkg::DEST_BITS-1:0]  src_tdest;
  logic [NP-1:0]                                 s_decode_err;

  `include "vio_switch_vectors.svh"

  // Expected packets per input/output pair, indexed src*NP+dest, in sending order
  int pair_ent [NP*NP][N_ROWS];
  int pair_cnt [NP*NP];
  int pair_pos [NP*NP];
  int beat_pos [NP*NP];
  int cur_src [NP];
  int last_src [NP];
  int err_cnt [NP];
  int err_exp [NP];
  logic [NP-1:0]                                stall_q;
  logic [NP-1:0][vio_switch_pkg::DATA_BITS-1:0] stall_data;
  int cycle_cnt;
  int timeout_cycles;
  integer seed;
  logic [31:0] rnd;

  vio_switch DUT (
    .aclk         (aclk),
    .rst          (rst),
    .sink_tvalid  (sink_tvalid),
    .sink_tready  (sink_tready),
    .sink_tdata   (sink_tdata),
    .sink_tkeep   (sink_tkeep),
    .sink_tlast   (sink_tlast),
    .sink_tid     (sink_tid),
    .sink_tdest   (sink_tdest),
    .src_tvalid   (src_tvalid),
    .src_tready   (src_tready),
    .src_tdata    (src_tdata),
    .src_tkeep    (src_tkeep),
    .src_tlast    (src_tlast),
    .src_tid      (src_tid),
    .src_tdest    (src_tdest),
    .s_decode_err (s_decode_err)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // Queue the good packets of a phase and count its bad ones
  task automatic load_phase(input int ph);
    int k;
    for (int r = 0; r < N_ROWS; r++) begin
      if (int'(ROWS[r].phase) == ph) begin
        if (is_bad_dest(r)) begin
          err_exp[ROWS[r].src]++;
        end else begin
          k = int'(ROWS[r].src) * NP + int'(ROWS[r].dest);
          pair_ent[k][pair_cnt[k]] = r;
          pair_cnt[k]++;
        end
      end
    end
  endtask

  // Valid stays high between packets of one input
  task automatic send_packets(input int p, input int ph);
    for (int r = 0; r < N_ROWS; r++) begin
      if (int'(ROWS[r].src) == p && int'(ROWS[r].phase) == ph) begin
        for (int b = 0; b < int'(ROWS[r].len); b++) begin
          sink_tvalid[p] <= 1'b1;
          sink_tdata[p]  <= beat_data(r, b);
          sink_tkeep[p]  <= beat_keep(r, b);
          sink_tlast[p]  <= (b == int'(ROWS[r].len) - 1);
          sink_tid[p]    <= ROWS[r].tid;
          sink_tdest[p]  <= ROWS[r].dest;
          @(posedge aclk);
          while (!sink_tready[p]) @(posedge aclk);
        end
      end
    end
    sink_tvalid[p] <= 1'b0;
  endtask

  function automatic logic all_delivered();
    for (int k = 0; k < NP * NP; k++) begin
      if (pair_pos[k] != pair_cnt[k]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_beat(input int o);
    int row;
    int src;
    int k;
    int exp_row;
    int b;
    row = int'(src_tdata[o][vio_switch_pkg::DATA_BITS-1:HALF]);
    expect_equal(64'(row >= 0 && row < N_ROWS), 64'd1, "beat carries a known row index");
    expect_equal(64'(is_bad_dest(row)), 64'd0, "dropped packet seen on an output");
    src = int'(ROWS[row].src);
    k = src * NP + o;
    expect_equal(64'(pair_pos[k] < pair_cnt[k]), 64'd1, "beat with no packet pending");
    if (cur_src[o] >= 0) begin
      expect_equal(64'(src), 64'(cur_src[o]), "packets interleaved on an output");
    end
    exp_row = pair_ent[k][pair_pos[k]];
    b = beat_pos[k];
    expect_equal(64'(src_tid[o]), 64'(ROWS[exp_row].tid), "packet order by tid");
    expect_equal(src_tdata[o], beat_data(exp_row, b), "tdata");
    expect_equal(64'(src_tkeep[o]), 64'(beat_keep(exp_row, b)), "tkeep");
    expect_equal(64'(src_tlast[o]), 64'(b == int'(ROWS[exp_row].len) - 1), "tlast");
    expect_equal(64'(src_tdest[o]), 64'(ROWS[exp_row].dest), "tdest");
    beat_pos[k]++;
    if (src_tlast[o]) begin
      // Same winner twice is only legal when no other input waits
      if (last_src[o] == src) begin
        for (int t = 0; t < NP; t++) begin
          if (t != src) begin
            expect_equal(64'(pair_cnt[t * NP + o] - pair_pos[t * NP + o]), 64'd0,
                         "round-robin skipped a waiting input");
          end
        end
      end
      last_src[o] = src;
      cur_src[o] = -1;
      beat_pos[k] = 0;
      pair_pos[k]++;
    end else begin
      cur_src[o] = src;
    end
  endtask

  // Output monitor, sampled at the edge where the transfer happens
  always @(posedge aclk) begin
    if (!rst) begin
      for (int o = 0; o < NP; o++) begin
        if (s_decode_err[o]) err_cnt[o]++;
        if (stall_q[o]) begin
          expect_equal(64'(src_tvalid[o]), 64'd1, "src_tvalid dropped during a stall");
          expect_equal(src_tdata[o], stall_data[o], "src_tdata changed during a stall");
        end
        stall_q[o] = src_tvalid[o] && !src_tready[o];
        stall_data[o] = src_tdata[o];
        if (src_tvalid[o] && src_tready[o]) begin
          check_beat(o);
        end
      end
    end
  end

  // Roughly three quarters ready per output
  always @(posedge aclk) begin
    rnd = $random(seed);
    src_tready <= rnd[3:0] | rnd[7:4];
  end

  always @(posedge aclk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      stop_with_failure();
    end
  end

  initial begin
    seed = 32'h99cd7b9e;
    timeout_cycles = total_beats() * 8 + 200;
    stall_q = '0;
    for (int i = 0; i < NP; i++) begin
      cur_src[i] = -1;
      last_src[i] = -1;
    end
    rst         <= 1'b1;
    sink_tvalid <= '0;
    sink_tdata  <= '0;
    sink_tkeep  <= '0;
    sink_tlast  <= '0;
    sink_tid    <= '0;
    sink_tdest  <= '0;
    src_tready  <= '0;
    repeat (8) @(posedge aclk);
    rst <= 1'b0;
    // Outputs stay quiet before any traffic
    repeat (4) begin
      @(posedge aclk);
      expect_equal(64'(src_tvalid), 64'd0, "src_tvalid after reset");
      expect_equal(64'(s_decode_err), 64'd0, "s_decode_err after reset");
    end
    for (int ph = 0; ph < N_PHASES; ph++) begin
      load_phase(ph);
      @(posedge aclk);
      fork
        send_packets(0, ph);
        send_packets(1, ph);
        send_packets(2, ph);
        send_packets(3, ph);
      join
      while (!all_delivered()) @(posedge aclk);
      repeat (2) @(posedge aclk);
      for (int i = 0; i < NP; i++) begin
        expect_equal(64'(err_cnt[i]), 64'(err_exp[i]), "s_decode_err pulse count");
      end
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+tb
hw/vio_switch_pkg.sv
hw/vio_ingress_decode.sv
hw/vio_egress_arbiter.sv
hw/vio_egress_slice.sv
hw/vio_switch.sv
tb/tb_vio_switch.sv
